//--- tut_pkg.sv
/*
 * Shared types and constants for the arcade front end.
 * Holds the keyboard, cabinet, host download, colour and
 * clock-management word layouts plus their fixed values.
 * Blocks refer to everything here by tut_pkg:: scoped names.
 */
package tut_pkg;

	// ================================================
	// Keyboard
	// ================================================

	// Host keyboard event, toggle flips once per event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	// Scan codes of the cabinet keys
	localparam logic [7:0] KEY_START1  = 8'h16;
	localparam logic [7:0] KEY_START2  = 8'h1E;
	localparam logic [7:0] KEY_COIN1   = 8'h2E;
	localparam logic [7:0] KEY_COIN2   = 8'h36;
	localparam logic [7:0] KEY_SERVICE = 8'h46;
	localparam logic [7:0] KEY_PAUSE   = 8'h4D;
	localparam logic [7:0] KEY_UP      = 8'h75;
	localparam logic [7:0] KEY_DOWN    = 8'h72;
	localparam logic [7:0] KEY_LEFT    = 8'h6B;
	localparam logic [7:0] KEY_RIGHT   = 8'h74;
	localparam logic [7:0] KEY_FIRE    = 8'h14;

	// Bit positions inside a joystick word
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE   = 4;
	localparam int JOY_START1 = 5;
	localparam int JOY_COIN1  = 6;
	localparam int JOY_START2 = 7;
	localparam int JOY_PAUSE  = 8;

	// Cabinet controls, every bit active low
	typedef struct packed {
		logic [1:0] coin;      // {coin2, coin1}
		logic [1:0] start;     // {start2, start1}
		logic [3:0] p1_joy;    // {right, left, down, up}
		logic [3:0] p2_joy;
		logic       p1_fire;
		logic       p2_fire;
		logic       service;
		logic       pause;     // for a later pause block
	} cabinet_t;

	// ================================================
	// Host download and DIP switches
	// ================================================

	typedef struct packed {
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  dout;
		logic [7:0]  index;
	} ioctl_t;

	localparam logic [7:0] DIP_INDEX = 8'd254;
	localparam int DIP_BYTES = 8;
	localparam int DIP_SEL_W = 3;   // Slot select bits of the address

	// ================================================
	// Video colour
	// ================================================

	typedef struct packed {
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
	} rgb5_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb8_t;

	// Resistor ladder weights, gun bit 0 first; they add up to FF
	localparam logic [7:0] TONE_W0 = 8'h19;
	localparam logic [7:0] TONE_W1 = 8'h24;
	localparam logic [7:0] TONE_W2 = 8'h35;
	localparam logic [7:0] TONE_W3 = 8'h40;
	localparam logic [7:0] TONE_W4 = 8'h4D;

	// ================================================
	// Clock reconfiguration
	// ================================================

	// Management write port of the reconfiguration block
	typedef struct packed {
		logic        write;
		logic [5:0]  address;
		logic [31:0] data;
	} pll_cfg_t;

	localparam logic [5:0] CFG_ADDR_MODE  = 6'd0;
	localparam logic [5:0] CFG_ADDR_MCNT  = 6'd7;
	localparam logic [5:0] CFG_ADDR_START = 6'd2;

	// M counter for native and underclocked speed
	localparam logic [31:0] MCNT_NATIVE = 32'd3639383488;
	localparam logic [31:0] MCNT_UNDER  = 32'd3268298314;

	// Sequence steps that carry a write
	localparam int SEQ_W = 3;
	localparam logic [SEQ_W-1:0] STEP_MODE  = 3'd1;
	localparam logic [SEQ_W-1:0] STEP_MCNT  = 3'd5;
	localparam logic [SEQ_W-1:0] STEP_START = 3'd7;

endpackage

//--- cabinet_inputs.sv
/*
 * Cabinet control merge.
 * Keyboard events set or clear one held button per known scan code.
 * Held buttons are ORed with the joystick words and inverted into
 * the active-low cabinet word. Key events show one edge later and
 * joystick changes show in the same cycle.
 */
module cabinet_inputs (
	input  logic              CLK_49M,
	input  logic              reset,
	input  tut_pkg::ps2_key_t ps2_key,
	input  logic [15:0]       joystick_0,
	input  logic [15:0]       joystick_1,
	output tut_pkg::cabinet_t cabinet
);

	// Held keyboard buttons as active-high flags
	typedef struct packed {
		logic start1;
		logic start2;
		logic coin1;
		logic coin2;
		logic service;
		logic pause;
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
	} kbd_btn_t;

	kbd_btn_t    btn;
	logic        toggle_q;
	logic        key_event;
	logic [15:0] joy_any;

	// ================================================
	// Keyboard decode
	// ================================================

	// New event whenever the toggle bit moves
	assign key_event = ps2_key.toggle != toggle_q;

	always_ff @(posedge CLK_49M) begin
		// Toggle value of the previous edge
		toggle_q <= ps2_key.toggle;
		if (reset) begin
			btn <= '0;
		end else if (key_event) begin
			case (ps2_key.code)
				tut_pkg::KEY_START1:  btn.start1  <= ps2_key.pressed;
				tut_pkg::KEY_START2:  btn.start2  <= ps2_key.pressed;
				tut_pkg::KEY_COIN1:   btn.coin1   <= ps2_key.pressed;
				tut_pkg::KEY_COIN2:   btn.coin2   <= ps2_key.pressed;
				tut_pkg::KEY_SERVICE: btn.service <= ps2_key.pressed;
				tut_pkg::KEY_PAUSE:   btn.pause   <= ps2_key.pressed;
				tut_pkg::KEY_UP:      btn.up      <= ps2_key.pressed;
				tut_pkg::KEY_DOWN:    btn.down    <= ps2_key.pressed;
				tut_pkg::KEY_LEFT:    btn.left    <= ps2_key.pressed;
				tut_pkg::KEY_RIGHT:   btn.right   <= ps2_key.pressed;
				tut_pkg::KEY_FIRE:    btn.fire    <= ps2_key.pressed;
				default: ;            // Other codes ignored
			endcase
		end
	end

	// ================================================
	// Merge with joysticks
	// ================================================

	// Start, coin 1 and pause accept either stick
	assign joy_any = joystick_0 | joystick_1;

	// One player's active-low directions {right, left, down, up}
	function automatic logic [3:0] dir_n(input kbd_btn_t k, input logic [15:0] joy);
		dir_n = ~{k.right | joy[tut_pkg::JOY_RIGHT],
		          k.left  | joy[tut_pkg::JOY_LEFT],
		          k.down  | joy[tut_pkg::JOY_DOWN],
		          k.up    | joy[tut_pkg::JOY_UP]};
	endfunction

	always_comb begin
		cabinet.coin    = ~{btn.coin2, btn.coin1 | joy_any[tut_pkg::JOY_COIN1]};
		cabinet.start   = ~{btn.start2 | joy_any[tut_pkg::JOY_START2],
		                    btn.start1 | joy_any[tut_pkg::JOY_START1]};
		// Keyboard drives both players
		cabinet.p1_joy  = dir_n(btn, joystick_0);
		cabinet.p2_joy  = dir_n(btn, joystick_1);
		cabinet.p1_fire = ~(btn.fire | joystick_0[tut_pkg::JOY_FIRE]);
		cabinet.p2_fire = ~(btn.fire | joystick_1[tut_pkg::JOY_FIRE]);
		// Service key only on the keyboard
		cabinet.service = ~btn.service;
		cabinet.pause   = ~(btn.pause | joy_any[tut_pkg::JOY_PAUSE]);
	end

endmodule

//--- dip_loader.sv
/*
 * DIP switch capture from the host download stream.
 * Bytes sent on the DIP index fill an eight-slot register file.
 * The board reads the first two slots as active-low banks.
 */
module dip_loader (
	input  logic            CLK_49M,
	input  logic            reset,
	input  tut_pkg::ioctl_t ioctl,
	output logic [15:0]     dip_sw
);

	logic [7:0] slot [tut_pkg::DIP_BYTES];
	logic       dip_wr;

	// DIP index and an address inside the first eight bytes
	assign dip_wr = ioctl.wr && (ioctl.index == tut_pkg::DIP_INDEX) &&
	                (ioctl.addr[24:tut_pkg::DIP_SEL_W] == '0);

	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			for (int i = 0; i < tut_pkg::DIP_BYTES; i++) begin
				slot[i] <= '0;
			end
		end else if (dip_wr) begin
			slot[ioctl.addr[tut_pkg::DIP_SEL_W-1:0]] <= ioctl.dout;
		end
	end

	// Bank 1 upper, bank 0 lower
	assign dip_sw = {~slot[1], ~slot[0]};

endmodule

//--- color_dac.sv
/*
 * Colour gun to 8-bit level conversion.
 * Each 5-bit gun is weighted bit by bit like the board's resistor
 * ladder and the three results are registered, one cycle latency.
 */
module color_dac (
	input  logic           CLK_49M,
	input  logic           reset,
	input  tut_pkg::rgb5_t gun_in,
	output tut_pkg::rgb8_t gun_out
);

	tut_pkg::rgb8_t level;

	// Sum of weights of the set bits, peaks at FF
	function automatic logic [7:0] tone(input logic [4:0] gun);
		logic [7:0] sum;
		sum = '0;
		if (gun[0]) sum = sum + tut_pkg::TONE_W0;
		if (gun[1]) sum = sum + tut_pkg::TONE_W1;
		if (gun[2]) sum = sum + tut_pkg::TONE_W2;
		if (gun[3]) sum = sum + tut_pkg::TONE_W3;
		if (gun[4]) sum = sum + tut_pkg::TONE_W4;
		return sum;
	endfunction

	// Same ladder on all three guns
	always_comb begin
		level.r = tone(gun_in.r);
		level.g = tone(gun_in.g);
		level.b = tone(gun_in.b);
	end

	// Output stage
	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			gun_out <= '0;
		end else begin
			gun_out <= level;
		end
	end

endmodule

//--- clock_reconfig_seq.sv
/*
 * Clock reconfiguration sequencer.
 * The underclock request is synchronised and, on a settled change,
 * a step counter walks through eight steps issuing three management
 * writes: mode, M counter and start. The management port stalls the
 * walk with waitrequest.
 */
module clock_reconfig_seq (
	input  logic              CLK_49M,
	input  logic              reset,
	input  logic              underclock,
	input  logic              cfg_waitrequest,
	output tut_pkg::pll_cfg_t pll_cfg
);

	logic                      uc_meta;
	logic                      uc_sync;
	logic                      uc_accepted;
	logic [tut_pkg::SEQ_W-1:0] step;
	logic                      write_step;

	// Steps that end in a management write
	assign write_step = (step == tut_pkg::STEP_MODE) ||
	                    (step == tut_pkg::STEP_MCNT) ||
	                    (step == tut_pkg::STEP_START);

	// ================================================
	// Request detect and step counter
	// ================================================

	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			uc_meta       <= 1'b0;
			uc_sync       <= 1'b0;
			uc_accepted   <= 1'b0;
			step          <= '0;
			pll_cfg.write <= 1'b0;
		end else begin
			// Two stage synchroniser
			uc_meta <= underclock;
			uc_sync <= uc_meta;

			// Write strobe lasts one cycle
			pll_cfg.write <= 1'b0;

			// Stable and new, restart the sequence
			if ((uc_sync == uc_meta) && (uc_sync != uc_accepted)) begin
				step        <= tut_pkg::STEP_MODE;
				uc_accepted <= uc_sync;
			end

			// Advance only while the port is free; 7 rolls to idle
			if (!cfg_waitrequest) begin
				if (step != '0)
					step <= step + 1'b1;
				pll_cfg.write <= write_step;
			end
		end
	end

	// ================================================
	// Write payload
	// ================================================

	always_ff @(posedge CLK_49M) begin
		if (!cfg_waitrequest) begin
			case (step)
				tut_pkg::STEP_MODE: begin
					pll_cfg.address <= tut_pkg::CFG_ADDR_MODE;
					pll_cfg.data    <= '0;
				end
				tut_pkg::STEP_MCNT: begin
					// Counter picked by the latched request
					pll_cfg.address <= tut_pkg::CFG_ADDR_MCNT;
					pll_cfg.data    <= uc_accepted ? tut_pkg::MCNT_UNDER
					                               : tut_pkg::MCNT_NATIVE;
				end
				tut_pkg::STEP_START: begin
					pll_cfg.address <= tut_pkg::CFG_ADDR_START;
					pll_cfg.data    <= '0;
				end
				default: ;
			endcase
		end
	end

endmodule

//--- tut_frontend.sv
/*
 * Board interface front end of the arcade core.
 * Four independent blocks share the clock and reset: cabinet
 * controls, DIP switch loading, colour conversion and the clock
 * reconfiguration sequencer. Each is driven only from top ports.
 */
module tut_frontend (
	input  logic              CLK_49M,
	input  logic              reset,

	// Host inputs
	input  tut_pkg::ps2_key_t ps2_key,
	input  logic [15:0]       joystick_0,
	input  logic [15:0]       joystick_1,
	input  tut_pkg::ioctl_t   ioctl,

	// Game board video
	input  tut_pkg::rgb5_t    gun_in,

	// Speed select and management port status
	input  logic              underclock,
	input  logic              cfg_waitrequest,

	// Towards the board and the display
	output tut_pkg::cabinet_t cabinet,
	output logic [15:0]       dip_sw,
	output tut_pkg::rgb8_t    gun_out,
	output tut_pkg::pll_cfg_t pll_cfg
);

	// ================================================
	// Controls and switches
	// ================================================

	cabinet_inputs cabinet_inputs_inst (
		.CLK_49M    (CLK_49M),
		.reset      (reset),
		.ps2_key    (ps2_key),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.cabinet    (cabinet)
	);

	dip_loader dip_loader_inst (
		.CLK_49M (CLK_49M),
		.reset   (reset),
		.ioctl   (ioctl),
		.dip_sw  (dip_sw)
	);

	// ================================================
	// Video and clocking
	// ================================================

	color_dac color_dac_inst (
		.CLK_49M (CLK_49M),
		.reset   (reset),
		.gun_in  (gun_in),
		.gun_out (gun_out)
	);

	// Native or underclocked system clock
	clock_reconfig_seq clock_reconfig_seq_inst (
		.CLK_49M         (CLK_49M),
		.reset           (reset),
		.underclock      (underclock),
		.cfg_waitrequest (cfg_waitrequest),
		.pll_cfg         (pll_cfg)
	);

endmodule

//--- tb_clock_gen.sv
/*
 * Testbench clock and reset source.
 * Free-running 20 ns clock and a synchronous reset held for the
 * first eight rising edges, released just after the eighth.
 */
module tb_clock_gen (
	output logic CLK_49M,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD  = 10;   // 20 ns period
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY  = 2;

	initial begin
		CLK_49M = 1'b0;
		forever #HALF_PERIOD CLK_49M = ~CLK_49M;
	end

	// Release lines up with the stimulus drive point
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK_49M);
		#DRIVE_DELAY;
		reset = 1'b0;
	end

endmodule

//--- tb_tut_frontend_sva.sv
/*
 * Concurrent checks on the front end, bound into the DUT top level.
 * Watches the clock reconfiguration write strobe against waitrequest
 * and the cabinet word as it comes out of reset.
 */
module tb_tut_frontend_sva (
	input logic              CLK_49M,
	input logic              reset,
	input logic              cfg_waitrequest,
	input logic              pll_write,
	input tut_pkg::cabinet_t cabinet
);
	timeunit 1ns;
	timeprecision 100ps;

	// Write strobe is a single-cycle pulse
	property write_single_pulse;
		@(posedge CLK_49M) disable iff (reset)
		pll_write |=> !pll_write;
	endproperty

	// A stalled management port never sees a write next cycle
	property write_after_free_port;
		@(posedge CLK_49M) disable iff (reset)
		cfg_waitrequest |=> !pll_write;
	endproperty

	// All buttons released once reset has acted
	property cabinet_idle_after_reset;
		@(posedge CLK_49M)
		reset |=> (cabinet == '1);
	endproperty

	write_single_pulse_a: assert property (write_single_pulse)
		else $error("pll_cfg.write high on two consecutive cycles");
	write_after_free_port_a: assert property (write_after_free_port)
		else $error("pll_cfg.write after a cycle with waitrequest high");
	cabinet_idle_after_reset_a: assert property (cabinet_idle_after_reset)
		else $error("cabinet word not all ones after reset");

endmodule

// Sequencer and cabinet ports as seen at the top level
bind tut_frontend tb_tut_frontend_sva tb_tut_frontend_sva_inst (
	.CLK_49M         (CLK_49M),
	.reset           (reset),
	.cfg_waitrequest (cfg_waitrequest),
	.pll_write       (pll_cfg.write),
	.cabinet         (cabinet)
);

//--- tb_tut_frontend.sv
/*
 * Testbench for the arcade board front end.
 * Drives keyboard, joystick, download, colour and speed-select
 * stimulus 2 ns after each rising edge, keeps reference models of
 * each block and compares the DUT outputs on every falling edge.
 */
module tb_tut_frontend;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DRIVE_DELAY   = 2;
	localparam int RESET_TIMEOUT = 40;
	localparam int WRITE_TIMEOUT = 200;
	localparam int NUM_KEYS      = 11;

	logic              CLK_49M;
	logic              reset;
	tut_pkg::ps2_key_t ps2_key;
	logic [15:0]       joystick_0;
	logic [15:0]       joystick_1;
	tut_pkg::ioctl_t   ioctl;
	tut_pkg::rgb5_t    gun_in;
	logic              underclock;
	logic              cfg_waitrequest;
	tut_pkg::cabinet_t cabinet;
	logic [15:0]       dip_sw;
	tut_pkg::rgb8_t    gun_out;
	tut_pkg::pll_cfg_t pll_cfg;

	// Reference state
	logic [7:0]          known [NUM_KEYS];   // start1 start2 coin1 coin2 service pause u d l r fire
	logic [NUM_KEYS-1:0] key_held;
	logic                toggle_seen;
	logic [7:0]          dip_model [tut_pkg::DIP_BYTES];
	tut_pkg::rgb8_t      gun_expect;
	tut_pkg::pll_cfg_t   write_queue [$];
	logic                check_en;
	int                  errors;
	integer              seed;

	tb_clock_gen clock_gen_inst (.CLK_49M(CLK_49M), .reset(reset));

	tut_frontend tut_frontend_inst (
		.CLK_49M (CLK_49M), .reset (reset), .ps2_key (ps2_key),
		.joystick_0 (joystick_0), .joystick_1 (joystick_1), .ioctl (ioctl),
		.gun_in (gun_in), .underclock (underclock), .cfg_waitrequest (cfg_waitrequest),
		.cabinet (cabinet), .dip_sw (dip_sw), .gun_out (gun_out), .pll_cfg (pll_cfg)
	);

	// ================================================
	// Reference functions
	// ================================================

	function automatic int key_index(input logic [7:0] code);
		for (int i = 0; i < NUM_KEYS; i++) begin
			if (known[i] == code)
				return i;
		end
		return -1;
	endfunction

	function automatic tut_pkg::cabinet_t cabinet_ref(input logic [NUM_KEYS-1:0] k,
			input logic [15:0] j0, input logic [15:0] j1);
		tut_pkg::cabinet_t c;
		logic [15:0]       both;
		both = j0 | j1;
		c.coin    = {!k[3], !(k[2] || both[tut_pkg::JOY_COIN1])};
		c.start   = {!(k[1] || both[tut_pkg::JOY_START2]),
		             !(k[0] || both[tut_pkg::JOY_START1])};
		// Shared keyboard directions with right as the top bit
		c.p1_joy  = {!(k[9] || j0[tut_pkg::JOY_RIGHT]), !(k[8] || j0[tut_pkg::JOY_LEFT]),
		             !(k[7] || j0[tut_pkg::JOY_DOWN]), !(k[6] || j0[tut_pkg::JOY_UP])};
		c.p2_joy  = {!(k[9] || j1[tut_pkg::JOY_RIGHT]), !(k[8] || j1[tut_pkg::JOY_LEFT]),
		             !(k[7] || j1[tut_pkg::JOY_DOWN]), !(k[6] || j1[tut_pkg::JOY_UP])};
		c.p1_fire = !(k[10] || j0[tut_pkg::JOY_FIRE]);
		c.p2_fire = !(k[10] || j1[tut_pkg::JOY_FIRE]);
		c.service = !k[4];
		c.pause   = !(k[5] || both[tut_pkg::JOY_PAUSE]);
		return c;
	endfunction

	// Weighted sum of the set gun bits
	function automatic logic [7:0] tone_ref(input logic [4:0] v);
		logic [7:0] w [5];
		int         acc;
		w = '{tut_pkg::TONE_W0, tut_pkg::TONE_W1, tut_pkg::TONE_W2,
		      tut_pkg::TONE_W3, tut_pkg::TONE_W4};
		acc = 0;
		for (int i = 0; i < 5; i++) begin
			if (v[i])
				acc += w[i];
		end
		return acc[7:0];
	endfunction

	function automatic tut_pkg::pll_cfg_t make_write(input logic [5:0] addr,
			input logic [31:0] data);
		tut_pkg::pll_cfg_t w;
		w.write   = 1'b1;
		w.address = addr;
		w.data    = data;
		return w;
	endfunction

	// ================================================
	// Checking
	// ================================================

	task automatic stop_with_failure();
		$display("Verification failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
			stop_with_failure();
		end
	endtask

	// Models follow the inputs present at each rising edge
	always @(posedge CLK_49M) begin
		int idx;
		if (reset) begin
			key_held = '0;
			for (int i = 0; i < tut_pkg::DIP_BYTES; i++)
				dip_model[i] = '0;
			gun_expect = '0;
		end else begin
			if (ps2_key.toggle != toggle_seen) begin
				idx = key_index(ps2_key.code);
				if (idx >= 0)
					key_held[idx] = ps2_key.pressed;
			end
			// DIP index and an address inside the first eight bytes
			if (ioctl.wr && ioctl.index == tut_pkg::DIP_INDEX &&
			    ioctl.addr[24:3] == '0)
				dip_model[ioctl.addr[2:0]] = ioctl.dout;
			gun_expect = {tone_ref(gun_in.r), tone_ref(gun_in.g), tone_ref(gun_in.b)};
		end
		toggle_seen = ps2_key.toggle;
	end

	// Outputs are settled by the falling edge
	always @(negedge CLK_49M) begin
		if (check_en) begin
			check_value("cabinet", cabinet, cabinet_ref(key_held, joystick_0, joystick_1));
			check_value("dip_sw", dip_sw, 16'(~{dip_model[1], dip_model[0]}));
			check_value("gun_out", gun_out, gun_expect);
			if (pll_cfg.write !== 1'b0) begin
				if (write_queue.size() == 0) begin
					$display("Clock configuration write at %0d ns when none was due", $time);
					stop_with_failure();
				end else begin
					check_value("pll_cfg", pll_cfg, write_queue.pop_front());
				end
			end
		end
	end

	// ================================================
	// Stimulus
	// ================================================

	task automatic next_cycle();
		@(posedge CLK_49M);
		#DRIVE_DELAY;
	endtask

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		@(posedge CLK_49M);
		while (reset !== 1'b0) begin
			if (waited == RESET_TIMEOUT) begin
				$display("Timeout: reset still active after %0d cycles", RESET_TIMEOUT);
				stop_with_failure();
			end
			waited++;
			@(posedge CLK_49M);
		end
		#DRIVE_DELAY;
	endtask

	// New speed setting and the three management writes in order
	task automatic switch_speed(input logic value);
		logic [31:0] r;
		int          waited;
		underclock = value;
		write_queue.push_back(make_write(tut_pkg::CFG_ADDR_MODE, '0));
		write_queue.push_back(make_write(tut_pkg::CFG_ADDR_MCNT,
			value ? tut_pkg::MCNT_UNDER : tut_pkg::MCNT_NATIVE));
		write_queue.push_back(make_write(tut_pkg::CFG_ADDR_START, '0));
		waited = 0;
		while (write_queue.size() != 0) begin
			if (waited == WRITE_TIMEOUT) begin
				$display("Timeout: %0d clock configuration writes never arrived",
					write_queue.size());
				stop_with_failure();
			end
			r = $random(seed);
			cfg_waitrequest = r[0];
			next_cycle();
			waited++;
		end
		// Any extra write shows on the quiet port
		cfg_waitrequest = 1'b0;
		repeat (12) next_cycle();
	endtask

	initial begin
		logic [31:0] r;
		int          k;
		seed = 32'hc3f1;
		known = '{tut_pkg::KEY_START1, tut_pkg::KEY_START2, tut_pkg::KEY_COIN1,
		          tut_pkg::KEY_COIN2, tut_pkg::KEY_SERVICE, tut_pkg::KEY_PAUSE,
		          tut_pkg::KEY_UP, tut_pkg::KEY_DOWN, tut_pkg::KEY_LEFT,
		          tut_pkg::KEY_RIGHT, tut_pkg::KEY_FIRE};
		ps2_key = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		ioctl = '0;
		gun_in = '0;
		underclock = 1'b0;
		cfg_waitrequest = 1'b0;
		toggle_seen = 1'b0;
		check_en = 1'b0;
		errors = 0;
		wait_reset_release();
		check_en = 1'b1;

		// Idle outputs with no sequence while underclock is low
		repeat (20) next_cycle();

		// Known and unknown key codes and events without a toggle
		for (int i = 0; i < 80; i++) begin
			r = $random(seed);
			k = r[7:4] % 14;
			ps2_key.code = (k < NUM_KEYS) ? known[k] : r[15:8];
			ps2_key.pressed = r[16];
			ps2_key.extended = r[17];
			if (r[20:18] != 0)
				ps2_key.toggle = ~ps2_key.toggle;
			next_cycle();
		end

		// Joysticks on top of whatever keys are held
		for (int i = 0; i < 60; i++) begin
			joystick_0 = 16'($random(seed));
			joystick_1 = 16'($random(seed));
			next_cycle();
		end
		joystick_0 = '0;
		joystick_1 = '0;

		// Download traffic mostly on the DIP index
		for (int i = 0; i < 80; i++) begin
			r = $random(seed);
			ioctl.wr = r[0] | r[1];
			ioctl.index = (r[3:2] != 0) ? tut_pkg::DIP_INDEX : r[31:24];
			ioctl.addr = 25'($random(seed));
			if (r[5:4] != 0)
				ioctl.addr[24:3] = '0;
			ioctl.dout = r[23:16];
			next_cycle();
		end
		ioctl = '0;

		for (int i = 0; i < 40; i++) begin
			gun_in = 15'($random(seed));
			next_cycle();
		end
		gun_in = '0;

		// Underclock on and off twice
		for (int i = 0; i < 4; i++)
			switch_speed(~underclock);

		next_cycle();
		if (errors == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			stop_with_failure();
		end
	end

endmodule

//--- verilog.f
tut_pkg.sv
cabinet_inputs.sv
dip_loader.sv
color_dac.sv
clock_reconfig_seq.sv
tut_frontend.sv
tb_clock_gen.sv
tb_tut_frontend_sva.sv
tb_tut_frontend.sv

//--- run_sim.sh
#!/bin/sh
# Build the front-end testbench with Verilator and run it.
# The run passes only when the pass message shows in the output.
out=""
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_tut_frontend \
	-f verilog.f -o tb_tut_frontend_sim &&
out=$(./obj_dir/tb_tut_frontend_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Verification passed" && echo "Result: PASS" ||
	{ echo "Result: FAIL"; exit 1; }
